// File: logic/adc_chan_params.svh
`ifndef ADC_CHAN_PARAMS_SVH
`define ADC_CHAN_PARAMS_SVH

////////////////////////////////////////
// sample and word widths
////////////////////////////////////////

`define ADC_SAMPLE_W 13   // raw adc code, over-range flag in the lsb
`define ADC_EXT_W    16   // one sample after sign extension
`define ADC_WORD_W   32   // memory word and frame beat width

////////////////////////////////////////
// depths
////////////////////////////////////////

`define ADC_MEM_AW   12   // data ring, 4096 words max

// header fifo holds 2**HDR_FIFO_AW entries
`define HDR_FIFO_AW  2
`define HDR_WORDS    3    // channel, trigger number, start address

`define SYNC_STAGES  2    // flops on arm and trig

`endif

// File: logic/adc_chan_pkg.sv
`include "adc_chan_params.svh"

package adc_chan_pkg;

  // one clock worth of adc data, two samples side by side
  typedef struct packed {
    logic [`ADC_SAMPLE_W-1:0] hi;   // later sample
    logic [`ADC_SAMPLE_W-1:0] lo;   // earlier sample
  } adc_pair_t;

  // same pair after sign extension, as stored in the ring
  typedef struct packed {
    logic [`ADC_EXT_W-1:0] hi;
    logic [`ADC_EXT_W-1:0] lo;
  } sample_word_t;

  // static configuration, buffer and post sizes must not move while armed
  typedef struct packed {
    logic [`ADC_MEM_AW:0]     buffer_size;        // words kept per acquisition
    logic [`ADC_MEM_AW-1:0]   post_trig_size;     // words written after the trigger
    logic [31:0]              channel_num;
    logic [31:0]              initial_trig_num;
    logic                     trig_num_we;        // load strobe for the trigger number
  } acq_cfg_t;

  // write side of the data ring
  typedef struct packed {
    logic                  we;
    logic [`ADC_MEM_AW-1:0] addr;
    sample_word_t          data;
  } mem_wr_t;

  // one entry per completed acquisition
  typedef struct packed {
    logic [31:0]            channel_num;
    logic [31:0]            trig_num;
    logic [`ADC_MEM_AW-1:0] start_addr;   // oldest word in the ring
  } header_t;

  // output beat, no back-pressure
  typedef struct packed {
    logic                   valid;
    logic                   last;
    logic [`ADC_WORD_W-1:0] data;
  } frame_t;

endpackage

// File: logic/adc_sample_pack.sv
`include "adc_chan_params.svh"

module adc_sample_pack import adc_chan_pkg::*; (
  input  logic         adc_clk,
  input  logic         rst_n,
  input  adc_pair_t    adc_dat,   // new pair every clock
  output sample_word_t sample     // registered, sign extended
);

  // copy bit 12 into the spare top bits of the 16-bit half
  function automatic logic [`ADC_EXT_W-1:0] sext(input logic [`ADC_SAMPLE_W-1:0] s);
    return {{(`ADC_EXT_W - `ADC_SAMPLE_W){s[`ADC_SAMPLE_W-1]}}, s};
  endfunction

  ////////////////////////////////////////
  // one pipeline stage
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      sample <= '0;
    end else begin
      sample.hi <= sext(adc_dat.hi);   // hi sample goes to the upper half
      sample.lo <= sext(adc_dat.lo);
    end
  end

  // over-range stays in bit 0 of each half, nothing to strip here

endmodule

// File: logic/sdp_ram.sv
module sdp_ram import adc_chan_pkg::*; #(
  parameter type payload_t = sample_word_t,   // word type stored
  parameter int  AW        = 12               // address bits
) (
  input  logic          adc_clk,
  input  logic          wr_en,
  input  logic [AW-1:0] wr_addr,
  input  payload_t      wr_data,
  input  logic [AW-1:0] rd_addr,
  output payload_t      rd_data     // valid one clock after rd_addr
);

  payload_t mem [2**AW];   // maps onto block or distributed ram

  ////////////////////////////////////////
  // write port
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  ////////////////////////////////////////
  // read port, output register
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    rd_data <= mem[rd_addr];   // old data on a same-address collision
  end

endmodule

// File: logic/acq_control.sv
`include "adc_chan_params.svh"

module acq_control import adc_chan_pkg::*; (
  input  logic         adc_clk,
  input  logic         rst_n,
  input  logic         acq_arm,            // async level from the master
  input  logic         acq_trig,           // async level, rising edge counts
  input  acq_cfg_t     cfg,
  input  sample_word_t sample,
  output mem_wr_t      mem_wr,
  input  logic         hdr_full,
  output logic         hdr_push,
  output header_t      hdr,
  output logic         acq_done,
  output logic [31:0]  current_trig_num
);

  typedef enum logic [2:0] {
    ST_IDLE,   // waiting for arm
    ST_FILL,   // running ring, trigger allowed once full
    ST_POST,   // post-trigger words
    ST_PUSH,   // header into fifo
    ST_DONE    // hold done until arm drops
  } acq_state_t;

  acq_state_t state;

  logic [`SYNC_STAGES-1:0] arm_sync;
  logic [`SYNC_STAGES-1:0] trig_sync;
  logic                    arm_s;        // synchronized arm
  logic                    trig_s;
  logic                    trig_q;       // trig_s one clock back
  logic                    trig_edge;    // registered rising edge

  logic [`ADC_MEM_AW-1:0]  wr_addr;      // next ring slot
  logic [`ADC_MEM_AW:0]    fill_cnt;     // words since arm, saturates
  logic [`ADC_MEM_AW-1:0]  post_cnt;
  logic [31:0]             trig_num;

  logic                    writing;
  logic                    last_addr;
  logic                    ring_full;
  logic                    qualified;
  logic                    post_end;

  ////////////////////////////////////////
  // synchronizers and edge detect
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      arm_sync  <= '0;
      trig_sync <= '0;
      trig_q    <= 1'b0;
      trig_edge <= 1'b0;
    end else begin
      arm_sync  <= {arm_sync[`SYNC_STAGES-2:0], acq_arm};
      trig_sync <= {trig_sync[`SYNC_STAGES-2:0], acq_trig};
      trig_q    <= trig_s;
      trig_edge <= trig_s & ~trig_q;   // one extra clock for the edge
    end
  end

  assign arm_s  = arm_sync[`SYNC_STAGES-1];
  assign trig_s = trig_sync[`SYNC_STAGES-1];

  assign writing   = (state == ST_FILL) || (state == ST_POST);
  assign last_addr = ({1'b0, wr_addr} == cfg.buffer_size - 1'b1);   // ring wraps here
  assign ring_full = (fill_cnt == cfg.buffer_size);
  assign qualified = (state == ST_FILL) && trig_edge && ring_full;   // early edges dropped
  assign post_end  = (post_cnt == cfg.post_trig_size - 1'b1);
  assign hdr_push  = (state == ST_PUSH) && !hdr_full;

  ////////////////////////////////////////
  // acquisition fsm and ring addressing
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      wr_addr  <= '0;
      fill_cnt <= '0;
      post_cnt <= '0;
    end else begin
      if (writing) begin
        wr_addr <= last_addr ? '0 : wr_addr + 1'b1;
      end
      case (state)
        ST_IDLE: begin
          if (arm_s) begin
            state    <= ST_FILL;
            fill_cnt <= '0;
            // resume where the last run stopped so a pending readout stays ahead,
            // restart only if the ring got smaller
            if ({1'b0, wr_addr} >= cfg.buffer_size) begin
              wr_addr <= '0;
            end
          end
        end
        ST_FILL: begin
          if (!arm_s) begin
            state <= ST_IDLE;                 // disarm aborts the fill
          end else begin
            if (!ring_full) begin
              fill_cnt <= fill_cnt + 1'b1;
            end
            if (qualified) begin
              post_cnt <= '0;
              state    <= (cfg.post_trig_size == '0) ? ST_PUSH : ST_POST;
            end
          end
        end
        ST_POST: begin
          if (!arm_s) begin
            state <= ST_IDLE;
          end else begin
            post_cnt <= post_cnt + 1'b1;
            if (post_end) begin
              state <= ST_PUSH;               // writing stops next clock
            end
          end
        end
        ST_PUSH: begin
          if (!hdr_full) begin
            state <= ST_DONE;                 // push happens this clock
          end
        end
        ST_DONE: begin
          if (!arm_s) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // trigger number
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      trig_num <= '0;
    end else if (cfg.trig_num_we) begin
      trig_num <= cfg.initial_trig_num;
    end else if (hdr_push) begin
      trig_num <= trig_num + 1'b1;    // header already took the old value
    end
  end

  assign current_trig_num = trig_num;

  // ring write port
  assign mem_wr.we   = writing;
  assign mem_wr.addr = wr_addr;
  assign mem_wr.data = sample;

  // header entry, start is the slot written next = oldest word
  assign hdr.channel_num = cfg.channel_num;
  assign hdr.trig_num    = trig_num;
  assign hdr.start_addr  = wr_addr;

  assign acq_done = hdr_push || (state == ST_DONE);   // high from the push clock on

endmodule

// File: logic/header_fifo.sv
`include "adc_chan_params.svh"

module header_fifo import adc_chan_pkg::*; (
  input  logic    adc_clk,
  input  logic    rst_n,
  input  logic    push,
  input  header_t din,
  input  logic    pop,
  output header_t dout,    // head entry, valid while !empty
  output logic    full,
  output logic    empty
);

  localparam logic [`HDR_FIFO_AW:0] FULL_CNT = {1'b1, {`HDR_FIFO_AW{1'b0}}};

  logic [`HDR_FIFO_AW-1:0] wr_ptr;
  logic [`HDR_FIFO_AW-1:0] rd_ptr;
  logic [`HDR_FIFO_AW:0]   count;       // entries pushed and not popped
  logic                    head_valid;  // prefetch register loaded
  logic                    rd_pend;     // ram read in flight
  logic                    wr_ok;
  logic                    pop_ok;
  logic                    fetch;
  header_t                 ram_q;
  header_t                 head;

  assign full   = (count == FULL_CNT);
  assign empty  = !head_valid;
  assign wr_ok  = push && !full;
  assign pop_ok = pop && head_valid;
  // refill the head when it and the read pipe are both free
  assign fetch  = (count != '0) && !head_valid && !rd_pend;

  sdp_ram #(
    .payload_t (header_t),
    .AW        (`HDR_FIFO_AW)
  ) i_store (
    .adc_clk (adc_clk),
    .wr_en   (wr_ok),
    .wr_addr (wr_ptr),
    .wr_data (din),
    .rd_addr (rd_ptr),
    .rd_data (ram_q)
  );

  ////////////////////////////////////////
  // pointers, count, prefetch control
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      head_valid <= 1'b0;
      rd_pend    <= 1'b0;
    end else begin
      if (wr_ok) wr_ptr <= wr_ptr + 1'b1;
      if (fetch) rd_ptr <= rd_ptr + 1'b1;
      rd_pend <= fetch;
      case ({wr_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (rd_pend) begin
        head_valid <= 1'b1;     // ram output lands in the head
      end else if (pop_ok) begin
        head_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (rd_pend) head <= ram_q;
  end

  assign dout = head;

endmodule

// File: logic/readout_ctrl.sv
`include "adc_chan_params.svh"

module readout_ctrl import adc_chan_pkg::*; (
  input  logic                   adc_clk,
  input  logic                   rst_n,
  input  logic [`ADC_MEM_AW:0]   buffer_size,
  input  header_t                hdr,
  input  logic                   hdr_empty,
  output logic                   hdr_pop,
  output logic [`ADC_MEM_AW-1:0] rd_addr,
  input  sample_word_t           rd_data,    // one clock behind rd_addr
  output frame_t                 frame
);

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_HDR,    // header words
    RD_DATA    // ring words, oldest first
  } rd_state_t;

  rd_state_t state;

  header_t                hdr_q;      // entry being sent
  logic [1:0]             hdr_idx;
  logic [`ADC_MEM_AW:0]   data_cnt;
  logic [`ADC_MEM_AW-1:0] rd_ptr;
  logic [`ADC_MEM_AW-1:0] rd_next;
  logic                   hdr_last;
  logic                   data_last;

  assign hdr_pop   = (state == RD_IDLE) && !hdr_empty;
  assign hdr_last  = (hdr_idx == 2'(`HDR_WORDS - 1));
  assign data_last = (data_cnt == buffer_size - 1'b1);
  // wrap at the ring size, not at the memory size
  assign rd_next   = ({1'b0, rd_ptr} == buffer_size - 1'b1) ? '0 : rd_ptr + 1'b1;
  assign rd_addr   = rd_ptr;

  ////////////////////////////////////////
  // sequencing
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      state    <= RD_IDLE;
      hdr_idx  <= '0;
      data_cnt <= '0;
      rd_ptr   <= '0;
    end else begin
      case (state)
        RD_IDLE: begin
          if (hdr_pop) begin
            state   <= RD_HDR;
            hdr_idx <= '0;
            rd_ptr  <= hdr.start_addr;   // first read issues during the header
          end
        end
        RD_HDR: begin
          hdr_idx <= hdr_idx + 1'b1;
          if (hdr_last) begin
            state    <= RD_DATA;
            data_cnt <= '0;
            rd_ptr   <= rd_next;      // word 0 already latched in the ram
          end
        end
        RD_DATA: begin
          data_cnt <= data_cnt + 1'b1;
          rd_ptr   <= rd_next;         // address k+1 while word k goes out
          if (data_last) begin
            state <= RD_IDLE;
          end
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge adc_clk) begin
    if (hdr_pop) hdr_q <= hdr;
  end

  ////////////////////////////////////////
  // output beat
  ////////////////////////////////////////

  always_comb begin
    frame = '0;
    case (state)
      RD_HDR: begin
        frame.valid = 1'b1;
        case (hdr_idx)
          2'd0:    frame.data = hdr_q.channel_num;
          2'd1:    frame.data = hdr_q.trig_num;
          default: frame.data[`ADC_MEM_AW-1:0] = hdr_q.start_addr;   // zero padded
        endcase
      end
      RD_DATA: begin
        frame.valid = 1'b1;
        frame.last  = data_last;
        frame.data  = rd_data;
      end
      default: frame = '0;
    endcase
  end

endmodule

// File: logic/adc_chan_top.sv
`include "adc_chan_params.svh"

module adc_chan_top import adc_chan_pkg::*; (
  input  logic        adc_clk,
  input  logic        rst_n,
  input  adc_pair_t   adc_dat,
  input  logic        acq_arm,            // async
  input  logic        acq_trig,           // async
  input  acq_cfg_t    cfg,
  output logic        acq_done,
  output logic [31:0] current_trig_num,
  output frame_t      frame
);

  sample_word_t           sample;        // packed and extended pair
  mem_wr_t                mem_wr;
  logic [`ADC_MEM_AW-1:0] mem_rd_addr;
  sample_word_t           mem_rd_data;
  header_t                hdr_in;
  header_t                hdr_out;
  logic                   hdr_push;
  logic                   hdr_pop;
  logic                   hdr_full;
  logic                   hdr_empty;

  ////////////////////////////////////////
  // acquisition side
  ////////////////////////////////////////

  adc_sample_pack i_pack (
    .adc_clk (adc_clk),
    .rst_n   (rst_n),
    .adc_dat (adc_dat),
    .sample  (sample)
  );

  acq_control i_acq (
    .adc_clk          (adc_clk),
    .rst_n            (rst_n),
    .acq_arm          (acq_arm),
    .acq_trig         (acq_trig),
    .cfg              (cfg),
    .sample           (sample),
    .mem_wr           (mem_wr),
    .hdr_full         (hdr_full),
    .hdr_push         (hdr_push),
    .hdr              (hdr_in),
    .acq_done         (acq_done),
    .current_trig_num (current_trig_num)
  );

  // data ring, write from acq_control, read from readout
  sdp_ram #(
    .payload_t (sample_word_t),
    .AW        (`ADC_MEM_AW)
  ) i_data_mem (
    .adc_clk (adc_clk),
    .wr_en   (mem_wr.we),
    .wr_addr (mem_wr.addr),
    .wr_data (mem_wr.data),
    .rd_addr (mem_rd_addr),
    .rd_data (mem_rd_data)
  );

  ////////////////////////////////////////
  // readout side
  ////////////////////////////////////////

  header_fifo i_hdr_fifo (
    .adc_clk (adc_clk),
    .rst_n   (rst_n),
    .push    (hdr_push),
    .din     (hdr_in),
    .pop     (hdr_pop),
    .dout    (hdr_out),
    .full    (hdr_full),
    .empty   (hdr_empty)
  );

  readout_ctrl i_readout (
    .adc_clk     (adc_clk),
    .rst_n       (rst_n),
    .buffer_size (cfg.buffer_size),
    .hdr         (hdr_out),
    .hdr_empty   (hdr_empty),
    .hdr_pop     (hdr_pop),
    .rd_addr     (mem_rd_addr),
    .rd_data     (mem_rd_data),
    .frame       (frame)
  );

endmodule

// File: tb/adc_chan_tb.sv
`include "adc_chan_params.svh"

module adc_chan_tb import adc_chan_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          MAX_LINES = 32;
  localparam int          COLS      = 6;               // fields per stim line
  localparam logic [31:0] CHAN_NUM  = 32'h0000_0003;   // fixed channel for the run

  logic        adc_clk = 1'b0;
  logic        rst_n;
  adc_pair_t   adc_dat;
  logic        acq_arm;
  logic        acq_trig;
  acq_cfg_t    cfg;
  logic        acq_done;
  logic [31:0] current_trig_num;
  frame_t      frame;

  logic [31:0] stim [COLS*MAX_LINES];
  int          n_lines;
  longint      limit_ns;         // watchdog budget
  integer      seed;
  logic [11:0] ramp_n;           // pair index with samples 2n and 2n+1
  logic [31:0] next_trig;        // model of the trigger number counter
  int          errors;
  int          frames_checked;

  // expected frames in trigger order
  logic [31:0] exp_trig_q [$];
  int          exp_bs_q [$];

  // frame checker state
  logic        in_frame;
  int          beat;
  int          cur_bs;
  logic [31:0] cur_trig;
  logic [15:0] prev_hi;

  adc_chan_top i_dut (
    .adc_clk          (adc_clk),
    .rst_n            (rst_n),
    .adc_dat          (adc_dat),
    .acq_arm          (acq_arm),
    .acq_trig         (acq_trig),
    .cfg              (cfg),
    .acq_done         (acq_done),
    .current_trig_num (current_trig_num),
    .frame            (frame)
  );

  always #5 adc_clk = ~adc_clk;   // 10 ns period

  // ramp source with one new pair on every falling edge
  always @(negedge adc_clk) begin
    adc_dat.lo <= {ramp_n, 1'b0};
    adc_dat.hi <= {ramp_n, 1'b1};
    ramp_n     <= ramp_n + 1'b1;   // wraps mod 8192 per sample
  end

  ////////////////////////////////////////
  // reporting helpers
  ////////////////////////////////////////

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      $display("error at %0d ns: %s = %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic require_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("at %0d ns: %s", $time, what);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // frame checker
  ////////////////////////////////////////

  task automatic collect_beat();
    sample_word_t w;
    w = frame.data;
    if (frame.valid) begin
      if (!in_frame) begin
        in_frame = 1'b1;
        beat     = 0;
        if (exp_trig_q.size() == 0) begin
          require_true(1'b0, "frame started with no acquisition pending");
          cur_trig = '1;
          cur_bs   = cfg.buffer_size;
        end else begin
          cur_trig = exp_trig_q.pop_front();
          cur_bs   = exp_bs_q.pop_front();
        end
      end
      case (beat)
        0: compare_value("frame.data (channel_num)", frame.data, CHAN_NUM);
        1: compare_value("frame.data (trig_num)", frame.data, cur_trig);
        2: require_true(frame.data < cur_bs, "header start address lies outside the ring");
        default: begin
          // sign bit copied into bits 15:13 of each half
          compare_value("frame.data.lo[15:13]", w.lo[15:13], {3{w.lo[12]}});
          compare_value("frame.data.hi[15:13]", w.hi[15:13], {3{w.hi[12]}});
          compare_value("frame.data.hi[12:0]", w.hi[12:0], 13'(w.lo[12:0] + 1'b1));
          if (beat > `HDR_WORDS) begin
            compare_value("frame.data.lo[12:0]", w.lo[12:0], 13'(prev_hi[12:0] + 1'b1));
          end
          prev_hi = w.hi;
        end
      endcase
      compare_value("frame.last", frame.last, beat == cur_bs + `HDR_WORDS - 1);
      if (frame.last || beat == cur_bs + `HDR_WORDS - 1) begin
        in_frame = 1'b0;   // resync on last even if early
        frames_checked++;
      end else begin
        beat++;
      end
    end else if (in_frame) begin
      require_true(1'b0, $sformatf("frame broke off after %0d beats", beat));
      in_frame = 1'b0;
    end
  endtask

  always @(negedge adc_clk) begin
    if (rst_n === 1'b1) collect_beat();
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  // wait until every expected frame has gone by
  task automatic wait_drain(input int max_cycles);
    int n;
    n = 0;
    while ((exp_trig_q.size() != 0 || in_frame) && n < max_cycles) begin
      @(negedge adc_clk);
      n++;
    end
    require_true(exp_trig_q.size() == 0 && !in_frame, "expected frames did not arrive");
  endtask

  task automatic run_line(input int idx);
    int          bs;
    int          pts;
    int          a2t;
    logic        ld;
    logic [31:0] ld_val;
    logic        want;
    logic        seen;
    int          n;
    bs     = stim[COLS*idx];
    pts    = stim[COLS*idx+1];
    a2t    = stim[COLS*idx+2];
    ld     = stim[COLS*idx+3][0];
    ld_val = stim[COLS*idx+4];
    want   = stim[COLS*idx+5][0];
    // readout wraps at the live ring size and must be idle before a resize
    if (bs != cfg.buffer_size) wait_drain(4 * (cfg.buffer_size + 30));
    @(negedge adc_clk);
    cfg.buffer_size    = bs[12:0];
    cfg.post_trig_size = pts[11:0];
    if (ld) begin
      cfg.trig_num_we      = 1'b1;
      cfg.initial_trig_num = ld_val;
      @(negedge adc_clk);
      cfg.trig_num_we = 1'b0;
      next_trig       = ld_val;
    end
    acq_arm = 1'b1;
    for (n = 0; n < a2t; n++) begin
      @(negedge adc_clk);
      require_true(!acq_done, "acq_done high before the trigger");
    end
    acq_trig = 1'b1;
    if (want) begin
      exp_trig_q.push_back(next_trig);
      exp_bs_q.push_back(bs);
    end
    repeat (2) @(negedge adc_clk);
    acq_trig = 1'b0;
    seen     = 1'b0;
    for (n = 0; n < pts + bs + 30 && !seen; n++) begin
      @(negedge adc_clk);
      seen = acq_done;
    end
    if (want) begin
      require_true(seen, "acq_done did not rise after a qualified trigger");
      next_trig++;
      if (seen) begin
        repeat (3) begin
          @(negedge adc_clk);
          require_true(acq_done, "acq_done dropped while arm was still high");
        end
      end
    end else begin
      require_true(!seen, "acq_done rose after a trigger that came too early");
    end
    compare_value("current_trig_num", current_trig_num, next_trig);
    acq_arm = 1'b0;
    for (n = 0; n < 10 && acq_done; n++) @(negedge adc_clk);
    require_true(!acq_done, "acq_done stayed high after arm dropped");
    repeat (3) @(negedge adc_clk);   // let the fsm see arm low
  endtask

  initial begin
    int     i;
    longint budget;
    rst_n    = 1'b0;
    acq_arm  = 1'b0;
    acq_trig = 1'b0;
    adc_dat  = '0;
    cfg      = '0;
    cfg.channel_num = CHAN_NUM;
    seed     = 32'h8dd9_2400;
    ramp_n   = 12'($random(seed));   // random ramp start
    errors   = 0;
    frames_checked = 0;
    next_trig = '0;
    in_frame = 1'b0;
    beat     = 0;
    cur_bs   = 0;
    cur_trig = '0;
    prev_hi  = '0;
    n_lines  = 0;
    limit_ns = 0;
    for (i = 0; i < COLS*MAX_LINES; i++) stim[i] = '1;   // all ones marks end of data
    $readmemh("tb/adc_chan_stim.txt", stim);
    while (n_lines < MAX_LINES && stim[COLS*n_lines] !== 32'hffff_ffff) n_lines++;
    require_true(n_lines > 0, "no stimulus lines read from tb/adc_chan_stim.txt");
    budget = 0;
    for (i = 0; i < n_lines; i++) begin
      budget += (stim[COLS*i+2] + stim[COLS*i+1] + 2 * stim[COLS*i] + 50) * 10;
    end
    limit_ns = budget;

    repeat (4) @(posedge adc_clk);
    @(negedge adc_clk);
    rst_n = 1'b1;
    @(negedge adc_clk);
    compare_value("acq_done", acq_done, 1'b0);
    compare_value("frame.valid", frame.valid, 1'b0);
    compare_value("current_trig_num", current_trig_num, 32'h0);

    for (i = 0; i < n_lines; i++) run_line(i);
    wait_drain(4 * (cfg.buffer_size + 30));
    repeat (5) @(negedge adc_clk);

    $display("summary: %0d errors, %0d frames checked", errors, frames_checked);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  ////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////

  initial begin
    wait (limit_ns > 0);
    #(limit_ns);
    $display("timeout: run did not finish within %0d ns", limit_ns);
    $display("summary: %0d errors, %0d frames checked", errors, frames_checked);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: adc_chan_top.f
+incdir+logic
logic/adc_chan_pkg.sv
logic/adc_sample_pack.sv
logic/sdp_ram.sv
logic/acq_control.sv
logic/header_fifo.sv
logic/readout_ctrl.sv
logic/adc_chan_top.sv
tb/adc_chan_tb.sv

// File: tb/adc_chan_stim.txt
// columns, all hex: buffer_size post_trig_size arm_to_trig load_flag load_value expect_frame
// arm_to_trig below buffer_size means the only trigger is too early and no frame may appear
010 004 012 1 00000010 1
010 004 012 0 00000000 1
010 008 014 0 00000000 1
010 004 006 0 00000000 0
010 004 012 0 00000000 1
020 010 024 1 fffffffe 1
020 000 022 0 00000000 1
020 008 008 0 00000000 0
020 006 022 0 00000000 1
040 020 044 0 00000000 1
040 010 042 0 00000000 1
040 010 042 1 00000100 1
00c 003 00e 0 00000000 1
00c 003 00e 0 00000000 1
00c 005 010 0 00000000 1
100 040 102 0 00000000 1
